// File: Bender.yml
package:
  name: dex

export_include_dirs:
  - include

sources:
  - files:
      - hw/dex_pkg.sv
      - hw/pair_fifo.sv
      - hw/dex_regfile.sv
      - hw/issue_stage.sv
      - hw/ex_forward.sv
      - hw/load_unit.sv
      - hw/ex_stage.sv
      - hw/dex_top.sv
  - target: test
    files:
      - dv/tb_dex_top.sv

// File: dv/tb_dex_top.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module tb_dex_top import dex_pkg::*; ();
    // Fill words, seed loads, directed, random and back-pressure pairs
    localparam int N_ITEMS = 64 + 31 + 6 + 3 + 5 + 6 + 40 + 30;
    localparam int LIMIT   = N_ITEMS * 4 + 200;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid;
    slot0_uop_u in_slot0;
    alu_uop_t in_slot1;
    logic in_ready;
    logic mem_wr_en;
    logic [`DEX_RAM_AW-1:0] mem_wr_addr;
    logic [`DEX_DATA_W-1:0] mem_wr_data;
    logic wb0_valid;
    logic wb1_valid;
    logic ld_wb_valid;
    logic stall;
    logic [`DEX_RF_AW-1:0] wb0_rd;
    logic [`DEX_RF_AW-1:0] wb1_rd;
    logic [`DEX_RF_AW-1:0] ld_wb_rd;
    logic [`DEX_DATA_W-1:0] wb0_data;
    logic [`DEX_DATA_W-1:0] wb1_data;
    logic [`DEX_DATA_W-1:0] ld_wb_data;

    // Reference state and expected {rd, data} per writeback port
    logic [31:0] regs_m [32];
    logic [31:0] ram_m [64];
    logic [36:0] q0[$];
    logic [36:0] q1[$];
    logic [36:0] ql[$];
    logic [31:0] lfsr = 32'h6304_bfba;
    logic prev_ld_valid = 1'b0;
    logic [4:0] prev_ld_rd = '0;
    logic stall_q = 1'b0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycles = 0;
    int exp_stalls = 0;
    int seen_stalls = 0;
    int ready_low = 0;
    int err_mark = 0;

    dex_top dex_top_i (.*);

    always #10 clk = ~clk;

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] compute_alu(input dex_op_e op, input logic [31:0] a,
                                                input logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    // Byte address low bits pick word and lane
    function automatic logic [31:0] load_value(input ld_type_e t, input logic [7:0] addr);
        logic [31:0] w;
        logic [7:0] b;
        logic [15:0] h;
        w = ram_m[addr[7:2]];
        b = 8'(w >> (addr[1:0] * 8));
        h = addr[1] ? w[31:16] : w[15:0];
        case (t)
            LD_B:    return {{24{b[7]}}, b};
            LD_BU:   return {24'h0, b};
            LD_H:    return {{16{h[15]}}, h};
            LD_HU:   return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic alu_uop_t make_alu(input dex_op_e op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        alu_uop_t u;
        u.op = op;
        u.rd = rd;
        u.rs1 = rs1;
        u.rs2 = rs2;
        u.pad = '0;
        return u;
    endfunction

    function automatic slot0_uop_u make_load(input logic [4:0] rd, input logic [4:0] base,
                                             input ld_type_e t, input logic [15:0] off);
        slot0_uop_u u;
        u.ld.op = OP_LOAD;
        u.ld.rd = rd;
        u.ld.base = base;
        u.ld.ld_type = t;
        u.ld.offset = off;
        return u;
    endfunction

    // In-order model applying slot 0 before slot 1
    task automatic apply_pair(input slot0_uop_u s0, input alu_uop_t s1);
        logic [31:0] v;
        logic [31:0] addr;
        if (s0.alu.op == OP_LOAD) begin
            addr = regs_m[s0.ld.base] + {{16{s0.ld.offset[15]}}, s0.ld.offset};
            v = load_value(s0.ld.ld_type, addr[7:0]);
            ql.push_back({s0.ld.rd, v});
            if (s0.ld.rd != 0 && (s1.rs1 == s0.ld.rd || s1.rs2 == s0.ld.rd))
                exp_stalls++;
            if (s0.ld.rd != 0) regs_m[s0.ld.rd] = v;
        end else if (s0.alu.op != OP_NOP) begin
            v = compute_alu(s0.alu.op, regs_m[s0.alu.rs1], regs_m[s0.alu.rs2]);
            q0.push_back({s0.alu.rd, v});
            if (s0.alu.rd != 0) regs_m[s0.alu.rd] = v;
        end
        if (s1.op != OP_NOP && s1.op != OP_LOAD) begin
            v = compute_alu(s1.op, regs_m[s1.rs1], regs_m[s1.rs2]);
            q1.push_back({s1.rd, v});
            if (s1.rd != 0) regs_m[s1.rd] = v;
        end
        prev_ld_valid = (s0.alu.op == OP_LOAD);
        prev_ld_rd = s0.alu.rd;
    endtask

    // Keep random pairs inside what the pipeline resolves
    task automatic fix_hazards(inout slot0_uop_u s0, inout alu_uop_t s1);
        if (s0.alu.op == OP_LOAD && s1.op != OP_NOP) begin
            // Slot 1 overwriting the load rd must wait on it
            if (s1.rd == s0.ld.rd) s1.rs1 = s0.ld.rd;
            if (s0.ld.rd != 0 && (s1.rs1 == s0.ld.rd || s1.rs2 == s0.ld.rd) && prev_ld_valid) begin
                if (s1.rs1 == prev_ld_rd) s1.rs1 = s0.ld.rd;
                if (s1.rs2 == prev_ld_rd) s1.rs2 = s0.ld.rd;
            end
        end
    endtask

    task automatic random_pair(output slot0_uop_u s0, output alu_uop_t s1);
        dex_op_e op;
        op = dex_op_e'(rand_bits(3));
        if (op == OP_LOAD)
            s0 = make_load(5'(rand_bits(5)), 5'(rand_bits(5)), ld_type_e'(rand_bits(3) % 5),
                           16'(rand_bits(16)));
        else
            s0.alu = make_alu(op, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
        op = dex_op_e'(rand_bits(3));
        if (op == OP_LOAD) op = OP_ADD;
        if (op == OP_NOP) s1 = make_alu(OP_NOP, '0, '0, '0);
        else s1 = make_alu(op, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
        fix_hazards(s0, s1);
    endtask

    task automatic send_pair(input slot0_uop_u s0, input alu_uop_t s1);
        while (!in_ready) begin
            @(posedge clk);
            #2;
        end
        in_slot0 = s0;
        in_slot1 = s1;
        in_valid = 1'b1;
        apply_pair(s0, s1);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        while (q0.size() != 0 || q1.size() != 0 || ql.size() != 0) begin
            @(posedge clk);
            #2;
        end
        repeat (2) @(posedge clk);
        #2;
        tests++;
        $display("test %-16s done, %0d new errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic check_wb(input string sig, input logic [4:0] rd, input logic [31:0] data,
                            ref logic [36:0] q[$]);
        logic [36:0] exp;
        checks++;
        assert (q.size() != 0) else begin
            $display("%s fired with no writeback pending in the model", sig);
            errors++;
        end
        if (q.size() != 0) begin
            exp = q.pop_front();
            assert (exp == {rd, data}) else begin
                $display("FAILED %s_rd/%s_data: expected %h/%h, got %h/%h",
                         sig, sig, exp[36:32], exp[31:0], rd, data);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (wb0_valid) check_wb("wb0", wb0_rd, wb0_data, q0);
            if (wb1_valid) check_wb("wb1", wb1_rd, wb1_data, q1);
            if (ld_wb_valid) check_wb("ld_wb", ld_wb_rd, ld_wb_data, ql);
            if (stall) seen_stalls++;
            assert (!(stall && stall_q)) else begin
                $display("stall stayed high for more than one cycle");
                errors++;
            end
            assert (!(stall && wb1_valid)) else begin
                $display("slot 1 wrote back during a load-use stall");
                errors++;
            end
            // Replay cycle has the load result out and slot 0 quiet
            assert (!(stall_q && (wb0_valid || !ld_wb_valid))) else begin
                $display("replay cycle had a slot-0 writeback or no load writeback");
                errors++;
            end
        end
        stall_q <= rst_n && stall;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("run hit the %0d cycle limit before draining", LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        slot0_uop_u s0;
        alu_uop_t s1;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_slot0 = '0;
        in_slot1 = '0;
        mem_wr_en = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        for (int i = 0; i < 32; i++) regs_m[i] = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        assert (in_ready) else begin
            $display("in_ready low after reset");
            errors++;
        end

        // RAM fill over the host port
        for (int i = 0; i < 64; i++) begin
            mem_wr_en = 1'b1;
            mem_wr_addr = 6'(i);
            mem_wr_data = rand_bits(32);
            ram_m[i] = mem_wr_data;
            @(posedge clk);
            #2;
        end
        mem_wr_en = 1'b0;

        // Seed registers with word loads off r0
        for (int i = 1; i < 32; i++)
            send_pair(make_load(5'(i), 5'd0, LD_W, 16'(i * 4)), make_alu(OP_NOP, 0, 0, 0));
        finish_test("seed_regs");

        for (int i = 0; i < 6; i++) begin
            s0.alu = make_alu(dex_op_e'(i), 5'(10 + i), 5'(i + 1), 5'(i + 2));
            send_pair(s0, make_alu(dex_op_e'(5 - i), 5'(24 + i), 5'(i + 3), 5'(9 - i)));
        end
        finish_test("alu_independent");

        s0.alu = make_alu(OP_ADD, 5'd12, 5'd1, 5'd2);
        send_pair(s0, make_alu(OP_XOR, 5'd13, 5'd12, 5'd3));
        s0.alu = make_alu(OP_SUB, 5'd0, 5'd4, 5'd5);
        send_pair(s0, make_alu(OP_OR, 5'd13, 5'd0, 5'd0));
        // Load to r0 neither stalls nor forwards
        send_pair(make_load(5'd0, 5'd0, LD_W, 16'd4), make_alu(OP_OR, 5'd13, 5'd0, 5'd0));
        finish_test("forward_same");

        for (int t = 0; t < 5; t++)
            send_pair(make_load(5'd14, 5'd5, ld_type_e'(t), 16'(t * 5 + 1)),
                      make_alu(OP_ADD, 5'd15, 5'd14, (t == 4) ? 5'd14 : 5'd6));
        finish_test("load_use");

        s0.alu = make_alu(OP_ADD, 5'd16, 5'd1, 5'd2);
        send_pair(s0, make_alu(OP_SUB, 5'd17, 5'd3, 5'd4));
        s0.alu = make_alu(OP_XOR, 5'd18, 5'd16, 5'd17);
        send_pair(s0, make_alu(OP_OR, 5'd19, 5'd16, 5'd18));
        send_pair(make_load(5'd20, 5'd0, LD_W, 16'd8), make_alu(OP_NOP, 0, 0, 0));
        s0.alu = make_alu(OP_ADD, 5'd21, 5'd20, 5'd1);
        send_pair(s0, make_alu(OP_AND, 5'd22, 5'd20, 5'd2));
        // Same rd in both slots leaves slot 1's value
        s0.alu = make_alu(OP_ADD, 5'd23, 5'd1, 5'd2);
        send_pair(s0, make_alu(OP_SUB, 5'd23, 5'd3, 5'd1));
        s0.alu = make_alu(OP_OR, 5'd24, 5'd23, 5'd0);
        send_pair(s0, make_alu(OP_NOP, 0, 0, 0));
        finish_test("back_to_back");

        for (int i = 0; i < 40; i++) begin
            random_pair(s0, s1);
            send_pair(s0, s1);
        end
        finish_test("random_pairs");

        // Offer a stalling pair every cycle and drop it while ready is low
        for (int i = 0; i < 30; i++) begin
            s0 = make_load(5'(rand_bits(5)) | 5'd1, 5'(rand_bits(5)), LD_W, 16'(rand_bits(8)));
            s1 = make_alu(OP_ADD, 5'(rand_bits(5)), s0.ld.rd, 5'(rand_bits(5)));
            fix_hazards(s0, s1);
            in_slot0 = s0;
            in_slot1 = s1;
            in_valid = 1'b1;
            if (in_ready) apply_pair(s0, s1);
            else ready_low++;
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
        assert (ready_low > 0) else begin
            $display("in_ready never dropped under back-pressure");
            errors++;
        end
        finish_test("back_pressure");

        assert (seen_stalls == exp_stalls) else begin
            $display("FAILED stall count: expected %h, got %h", exp_stalls, seen_stalls);
            errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: hw/dex_pkg.sv
`include "dex_defines.svh"

package dex_pkg;

    // Micro-op opcodes, shared by both slots
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_LOAD,
        OP_NOP
    } dex_op_e;

    // Load width and extension
    typedef enum logic [2:0] {
        LD_W,
        LD_B,
        LD_BU,
        LD_H,
        LD_HU
    } ld_type_e;

    // ALU view, also the slot-1 word
    typedef struct packed {
        dex_op_e               op;
        logic [`DEX_RF_AW-1:0] rd;
        logic [`DEX_RF_AW-1:0] rs1;
        logic [`DEX_RF_AW-1:0] rs2;
        logic [13:0]           pad;
    } alu_uop_t;

    // Load view, opcode and rd line up with the ALU view
    typedef struct packed {
        dex_op_e               op;
        logic [`DEX_RF_AW-1:0] rd;
        logic [`DEX_RF_AW-1:0] base;
        ld_type_e              ld_type;
        logic [15:0]           offset;
    } ld_uop_t;

    // Slot-0 word, view picked by opcode
    typedef union packed {
        alu_uop_t alu;
        ld_uop_t  ld;
    } slot0_uop_u;

    // Shared ALU; LOAD adds base and offset for the address
    function automatic logic [`DEX_DATA_W-1:0] dex_alu(
        input dex_op_e                op,
        input logic [`DEX_DATA_W-1:0] a,
        input logic [`DEX_DATA_W-1:0] b
    );
        logic [`DEX_DATA_W-1:0] res;
        case (op)
            OP_ADD, OP_LOAD: res = a + b;
            OP_SUB:          res = a - b;
            OP_AND:          res = a & b;
            OP_OR:           res = a | b;
            OP_XOR:          res = a ^ b;
            OP_SLL:          res = a << b[4:0];
            default:         res = '0;
        endcase
        return res;
    endfunction

endpackage

// File: hw/dex_regfile.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module dex_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DEX_RF_AW-1:0]  ra0a,
    input  logic [`DEX_RF_AW-1:0]  ra0b,
    input  logic [`DEX_RF_AW-1:0]  ra1a,
    input  logic [`DEX_RF_AW-1:0]  ra1b,
    output logic [`DEX_DATA_W-1:0] rd0a,
    output logic [`DEX_DATA_W-1:0] rd0b,
    output logic [`DEX_DATA_W-1:0] rd1a,
    output logic [`DEX_DATA_W-1:0] rd1b,
    input  logic                   we0,
    input  logic [`DEX_RF_AW-1:0]  wa0,
    input  logic [`DEX_DATA_W-1:0] wd0,
    input  logic                   we1,
    input  logic [`DEX_RF_AW-1:0]  wa1,
    input  logic [`DEX_DATA_W-1:0] wd1,
    input  logic                   wel,
    input  logic [`DEX_RF_AW-1:0]  wal,
    input  logic [`DEX_DATA_W-1:0] wdl
);
    logic [`DEX_DATA_W-1:0] regs [`DEX_RF_N];

    // Write-first read, same priority as the write side
    function automatic logic [`DEX_DATA_W-1:0] rd_port(input logic [`DEX_RF_AW-1:0] ra);
        logic [`DEX_DATA_W-1:0] val;
        if (ra == '0) begin
            val = '0;
        end else if (we1 && wa1 == ra) begin
            val = wd1;
        end else if (we0 && wa0 == ra) begin
            val = wd0;
        end else if (wel && wal == ra) begin
            val = wdl;
        end else begin
            val = regs[ra];
        end
        return val;
    endfunction

    always_comb begin
        rd0a = rd_port(ra0a);
        rd0b = rd_port(ra0b);
        rd1a = rd_port(ra1a);
        rd1b = rd_port(ra1b);
    end

    // Younger write wins: slot 1, then slot 0, then load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DEX_RF_N; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // r0 never written
            for (int i = 1; i < `DEX_RF_N; i++) begin
                if (we1 && wa1 == `DEX_RF_AW'(i)) begin
                    regs[i] <= wd1;
                end else if (we0 && wa0 == `DEX_RF_AW'(i)) begin
                    regs[i] <= wd0;
                end else if (wel && wal == `DEX_RF_AW'(i)) begin
                    regs[i] <= wdl;
                end
            end
        end
    end

endmodule

// File: hw/dex_top.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module dex_top import dex_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  slot0_uop_u             in_slot0,
    input  alu_uop_t               in_slot1,
    output logic                   in_ready,
    input  logic                   mem_wr_en,
    input  logic [`DEX_RAM_AW-1:0] mem_wr_addr,
    input  logic [`DEX_DATA_W-1:0] mem_wr_data,
    output logic                   wb0_valid,
    output logic [`DEX_RF_AW-1:0]  wb0_rd,
    output logic [`DEX_DATA_W-1:0] wb0_data,
    output logic                   wb1_valid,
    output logic [`DEX_RF_AW-1:0]  wb1_rd,
    output logic [`DEX_DATA_W-1:0] wb1_data,
    output logic                   ld_wb_valid,
    output logic [`DEX_RF_AW-1:0]  ld_wb_rd,
    output logic [`DEX_DATA_W-1:0] ld_wb_data,
    output logic                   stall
);
    slot0_uop_u             head_slot0;
    alu_uop_t               head_slot1;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   pop;
    logic                   accept;
    logic                   issue_valid;
    logic [`DEX_RF_AW-1:0]  ra0a;
    logic [`DEX_RF_AW-1:0]  ra0b;
    logic [`DEX_RF_AW-1:0]  ra1a;
    logic [`DEX_RF_AW-1:0]  ra1b;
    logic [`DEX_DATA_W-1:0] rd0a;
    logic [`DEX_DATA_W-1:0] rd0b;
    logic [`DEX_DATA_W-1:0] rd1a;
    logic [`DEX_DATA_W-1:0] rd1b;

    // Ready is the queue's not-full level
    assign in_ready = !fifo_full;

    pair_fifo pair_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_slot0(in_slot0),
        .push_slot1(in_slot1),
        .pop       (pop),
        .head_slot0(head_slot0),
        .head_slot1(head_slot1),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    issue_stage issue_stage_i (
        .head_slot0 (head_slot0),
        .head_slot1 (head_slot1),
        .empty      (fifo_empty),
        .accept     (accept),
        .ra0a       (ra0a),
        .ra0b       (ra0b),
        .ra1a       (ra1a),
        .ra1b       (ra1b),
        .issue_valid(issue_valid),
        .pop        (pop)
    );

    // ALU writebacks on ports 0 and 1, load on the third
    dex_regfile dex_regfile_i (
        .clk  (clk),
        .rst_n(rst_n),
        .ra0a (ra0a),
        .ra0b (ra0b),
        .ra1a (ra1a),
        .ra1b (ra1b),
        .rd0a (rd0a),
        .rd0b (rd0b),
        .rd1a (rd1a),
        .rd1b (rd1b),
        .we0  (wb0_valid),
        .wa0  (wb0_rd),
        .wd0  (wb0_data),
        .we1  (wb1_valid),
        .wa1  (wb1_rd),
        .wd1  (wb1_data),
        .wel  (ld_wb_valid),
        .wal  (ld_wb_rd),
        .wdl  (ld_wb_data)
    );

    ex_stage ex_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_valid(issue_valid),
        .issue_slot0(head_slot0),
        .issue_slot1(head_slot1),
        .val0_a     (rd0a),
        .val0_b     (rd0b),
        .val1_a     (rd1a),
        .val1_b     (rd1b),
        .mem_wr_en  (mem_wr_en),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .accept     (accept),
        .stall      (stall),
        .wb0_valid  (wb0_valid),
        .wb0_rd     (wb0_rd),
        .wb0_data   (wb0_data),
        .wb1_valid  (wb1_valid),
        .wb1_rd     (wb1_rd),
        .wb1_data   (wb1_data),
        .ld_wb_valid(ld_wb_valid),
        .ld_wb_rd   (ld_wb_rd),
        .ld_wb_data (ld_wb_data)
    );

endmodule

// File: hw/ex_forward.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module ex_forward (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`DEX_RF_AW-1:0]  slot0_rd,
    input  logic                   slot0_wr_en,
    input  logic                   slot0_is_load,
    input  logic [`DEX_DATA_W-1:0] slot0_data,
    input  logic [`DEX_RF_AW-1:0]  slot1_rs1,
    input  logic [`DEX_RF_AW-1:0]  slot1_rs2,
    input  logic [`DEX_DATA_W-1:0] slot1_val_a,
    input  logic [`DEX_DATA_W-1:0] slot1_val_b,
    input  logic [`DEX_RF_AW-1:0]  slot0_rs_a,
    input  logic [`DEX_RF_AW-1:0]  slot0_rs_b,
    input  logic [`DEX_DATA_W-1:0] slot0_val_a,
    input  logic [`DEX_DATA_W-1:0] slot0_val_b,
    input  logic                   wb_ld_en,
    input  logic [`DEX_RF_AW-1:0]  wb_ld_rd,
    input  logic [`DEX_DATA_W-1:0] wb_ld_data,
    output logic [`DEX_DATA_W-1:0] slot0_op_a,
    output logic [`DEX_DATA_W-1:0] slot0_op_b,
    output logic [`DEX_DATA_W-1:0] slot1_op_a,
    output logic [`DEX_DATA_W-1:0] slot1_op_b,
    output logic                   stall,
    output logic                   replay
);
    logic alu_hit_1a;
    logic alu_hit_1b;
    logic ld_hit_1a;
    logic ld_hit_1b;
    logic ld_hit_0a;
    logic ld_hit_0b;

    // Same-cycle slot 0 to slot 1, r0 excluded
    assign alu_hit_1a = slot0_wr_en && slot0_rd != '0 && slot0_rd == slot1_rs1;
    assign alu_hit_1b = slot0_wr_en && slot0_rd != '0 && slot0_rd == slot1_rs2;

    // Load writeback register hits
    assign ld_hit_1a = wb_ld_en && wb_ld_rd != '0 && wb_ld_rd == slot1_rs1;
    assign ld_hit_1b = wb_ld_en && wb_ld_rd != '0 && wb_ld_rd == slot1_rs2;
    assign ld_hit_0a = wb_ld_en && wb_ld_rd != '0 && wb_ld_rd == slot0_rs_a;
    assign ld_hit_0b = wb_ld_en && wb_ld_rd != '0 && wb_ld_rd == slot0_rs_b;

    // Slot 1: slot-0 result, then load data, then register
    assign slot1_op_a = alu_hit_1a ? slot0_data : (ld_hit_1a ? wb_ld_data : slot1_val_a);
    assign slot1_op_b = alu_hit_1b ? slot0_data : (ld_hit_1b ? wb_ld_data : slot1_val_b);

    // Slot 0 only sees older loads
    assign slot0_op_a = ld_hit_0a ? wb_ld_data : slot0_val_a;
    assign slot0_op_b = ld_hit_0b ? wb_ld_data : slot0_val_b;

    // Load-use hazard, never raised twice for one pair
    assign stall = slot0_is_load && !replay && slot0_rd != '0 &&
                   (slot0_rd == slot1_rs1 || slot0_rd == slot1_rs2);

    // Next cycle replays slot 1 alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            replay <= 1'b0;
        end else begin
            replay <= stall;
        end
    end

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module ex_stage import dex_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  slot0_uop_u             issue_slot0,
    input  alu_uop_t               issue_slot1,
    input  logic [`DEX_DATA_W-1:0] val0_a,
    input  logic [`DEX_DATA_W-1:0] val0_b,
    input  logic [`DEX_DATA_W-1:0] val1_a,
    input  logic [`DEX_DATA_W-1:0] val1_b,
    input  logic                   mem_wr_en,
    input  logic [`DEX_RAM_AW-1:0] mem_wr_addr,
    input  logic [`DEX_DATA_W-1:0] mem_wr_data,
    output logic                   accept,
    output logic                   stall,
    output logic                   wb0_valid,
    output logic [`DEX_RF_AW-1:0]  wb0_rd,
    output logic [`DEX_DATA_W-1:0] wb0_data,
    output logic                   wb1_valid,
    output logic [`DEX_RF_AW-1:0]  wb1_rd,
    output logic [`DEX_DATA_W-1:0] wb1_data,
    output logic                   ld_wb_valid,
    output logic [`DEX_RF_AW-1:0]  ld_wb_rd,
    output logic [`DEX_DATA_W-1:0] ld_wb_data
);
    // Execute register
    logic                   ex_valid;
    slot0_uop_u             ex_slot0;
    alu_uop_t               ex_slot1;
    logic [`DEX_DATA_W-1:0] ex_val0_a;
    logic [`DEX_DATA_W-1:0] ex_val0_b;
    logic [`DEX_DATA_W-1:0] ex_val1_a;
    logic [`DEX_DATA_W-1:0] ex_val1_b;

    logic                   replay;
    logic                   s0_is_load;
    logic                   s0_is_alu;
    logic                   s1_is_alu;
    logic                   ld_en;
    logic [`DEX_RF_AW-1:0]  s0_rs_a;
    logic [`DEX_RF_AW-1:0]  s0_rs_b;
    logic [`DEX_DATA_W-1:0] op0_a;
    logic [`DEX_DATA_W-1:0] op0_b;
    logic [`DEX_DATA_W-1:0] op1_a;
    logic [`DEX_DATA_W-1:0] op1_b;
    logic [`DEX_DATA_W-1:0] ld_off;
    logic [`DEX_DATA_W-1:0] s0_result;

    // Stall holds the whole execute register
    assign accept = !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (accept) begin
            ex_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_slot0  <= issue_slot0;
            ex_slot1  <= issue_slot1;
            ex_val0_a <= val0_a;
            ex_val0_b <= val0_b;
            ex_val1_a <= val1_a;
            ex_val1_b <= val1_b;
        end
    end

    // Slot-0 decode by opcode
    assign s0_is_load = (ex_slot0.alu.op == OP_LOAD);
    assign s0_is_alu  = (ex_slot0.alu.op != OP_LOAD) && (ex_slot0.alu.op != OP_NOP);
    assign s1_is_alu  = (ex_slot1.op != OP_LOAD) && (ex_slot1.op != OP_NOP);
    // Load base sits on the rs1 bits
    assign s0_rs_a    = ex_slot0.alu.rs1;
    assign s0_rs_b    = s0_is_load ? '0 : ex_slot0.alu.rs2;

    ex_forward ex_forward_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot0_rd     (ex_slot0.alu.rd),
        .slot0_wr_en  (wb0_valid),
        .slot0_is_load(ex_valid && s0_is_load),
        .slot0_data   (s0_result),
        .slot1_rs1    (ex_slot1.rs1),
        .slot1_rs2    (ex_slot1.rs2),
        .slot1_val_a  (ex_val1_a),
        .slot1_val_b  (ex_val1_b),
        .slot0_rs_a   (s0_rs_a),
        .slot0_rs_b   (s0_rs_b),
        .slot0_val_a  (ex_val0_a),
        .slot0_val_b  (ex_val0_b),
        .wb_ld_en     (ld_wb_valid),
        .wb_ld_rd     (ld_wb_rd),
        .wb_ld_data   (ld_wb_data),
        .slot0_op_a   (op0_a),
        .slot0_op_b   (op0_b),
        .slot1_op_a   (op1_a),
        .slot1_op_b   (op1_b),
        .stall        (stall),
        .replay       (replay)
    );

    // Load address is base plus sign-extended offset
    assign ld_off    = {{(`DEX_DATA_W-16){ex_slot0.ld.offset[15]}}, ex_slot0.ld.offset};
    assign s0_result = dex_alu(ex_slot0.alu.op, op0_a, s0_is_load ? ld_off : op0_b);

    // Slot 0 suppressed on replay
    assign ld_en     = ex_valid && s0_is_load && !replay;
    assign wb0_valid = ex_valid && s0_is_alu && !replay;
    assign wb0_rd    = ex_slot0.alu.rd;
    assign wb0_data  = s0_result;

    // Slot 1 waits out the load-use cycle
    assign wb1_valid = ex_valid && s1_is_alu && !stall;
    assign wb1_rd    = ex_slot1.rd;
    assign wb1_data  = dex_alu(ex_slot1.op, op1_a, op1_b);

    load_unit load_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld_en      (ld_en),
        .ld_rd      (ex_slot0.ld.rd),
        .ld_type    (ex_slot0.ld.ld_type),
        .ld_addr    (s0_result[`DEX_RAM_AW+1:0]),
        .mem_wr_en  (mem_wr_en),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data),
        .ld_wb_valid(ld_wb_valid),
        .ld_wb_rd   (ld_wb_rd),
        .ld_wb_data (ld_wb_data)
    );

endmodule

// File: hw/issue_stage.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module issue_stage import dex_pkg::*; (
    input  slot0_uop_u            head_slot0,
    input  alu_uop_t              head_slot1,
    input  logic                  empty,
    input  logic                  accept,
    output logic [`DEX_RF_AW-1:0] ra0a,
    output logic [`DEX_RF_AW-1:0] ra0b,
    output logic [`DEX_RF_AW-1:0] ra1a,
    output logic [`DEX_RF_AW-1:0] ra1b,
    output logic                  issue_valid,
    output logic                  pop
);
    // Opcode sits at the same bits in both views
    always_comb begin
        case (head_slot0.alu.op)
            OP_LOAD: begin
                // Base on port a, offset needs no register
                ra0a = head_slot0.ld.base;
                ra0b = '0;
            end
            OP_NOP: begin
                ra0a = '0;
                ra0b = '0;
            end
            default: begin
                ra0a = head_slot0.alu.rs1;
                ra0b = head_slot0.alu.rs2;
            end
        endcase
    end

    // Slot 1 is always the ALU view
    assign ra1a = head_slot1.rs1;
    assign ra1b = head_slot1.rs2;

    // Pair ready whenever queue holds one
    assign issue_valid = !empty;

    // Pop only when execute takes the pair
    assign pop = accept && !empty;

endmodule

// File: hw/load_unit.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module load_unit import dex_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ld_en,
    input  logic [`DEX_RF_AW-1:0]   ld_rd,
    input  ld_type_e                ld_type,
    input  logic [`DEX_RAM_AW+1:0]  ld_addr,
    input  logic                    mem_wr_en,
    input  logic [`DEX_RAM_AW-1:0]  mem_wr_addr,
    input  logic [`DEX_DATA_W-1:0]  mem_wr_data,
    output logic                    ld_wb_valid,
    output logic [`DEX_RF_AW-1:0]   ld_wb_rd,
    output logic [`DEX_DATA_W-1:0]  ld_wb_data
);
    logic [`DEX_DATA_W-1:0] ram [2**`DEX_RAM_AW];

    logic [`DEX_DATA_W-1:0] ld_word;
    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [`DEX_DATA_W-1:0] ld_ext;

    // Word from upper bits; no alignment trap
    assign ld_word = ram[ld_addr[`DEX_RAM_AW+1:2]];
    assign ld_byte = ld_word[{ld_addr[1:0], 3'b000} +: 8];
    // Half lane from bit 1 only
    assign ld_half = ld_word[{ld_addr[1], 4'b0000} +: 16];

    // Width select and extension
    always_comb begin
        case (ld_type)
            LD_B:    ld_ext = {{(`DEX_DATA_W-8){ld_byte[7]}}, ld_byte};
            LD_BU:   ld_ext = {{(`DEX_DATA_W-8){1'b0}}, ld_byte};
            LD_H:    ld_ext = {{(`DEX_DATA_W-16){ld_half[15]}}, ld_half};
            LD_HU:   ld_ext = {{(`DEX_DATA_W-16){1'b0}}, ld_half};
            default: ld_ext = ld_word;
        endcase
    end

    // Host fill port and memory-writeback register
    always_ff @(posedge clk) begin
        if (mem_wr_en) begin
            ram[mem_wr_addr] <= mem_wr_data;
        end
        if (ld_en) begin
            ld_wb_rd   <= ld_rd;
            ld_wb_data <= ld_ext;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_wb_valid <= 1'b0;
        end else begin
            ld_wb_valid <= ld_en;
        end
    end

endmodule

// File: hw/pair_fifo.sv
`timescale 1ns/1ns
`include "dex_defines.svh"

module pair_fifo import dex_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  slot0_uop_u push_slot0,
    input  alu_uop_t   push_slot1,
    input  logic       pop,
    output slot0_uop_u head_slot0,
    output alu_uop_t   head_slot1,
    output logic       empty,
    output logic       full
);
    localparam int PTR_W = $clog2(`DEX_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`DEX_FIFO_DEPTH + 1);

    // Pair storage, one array per slot
    slot0_uop_u mem0 [`DEX_FIFO_DEPTH];
    alu_uop_t   mem1 [`DEX_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Push dropped when full, pop ignored when empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(`DEX_FIFO_DEPTH));

    // Head is visible without a read cycle
    assign head_slot0 = mem0[rd_ptr];
    assign head_slot1 = mem1[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap explicitly in case depth is not a power of two
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`DEX_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`DEX_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem0[wr_ptr] <= push_slot0;
            mem1[wr_ptr] <= push_slot1;
        end
    end

endmodule

// File: include/dex_defines.svh
`ifndef DEX_DEFINES_SVH
`define DEX_DEFINES_SVH

// Operand and result width
`define DEX_DATA_W 32

// Register file geometry
`define DEX_RF_AW 5
`define DEX_RF_N 32

// Pairs held in the input queue
`define DEX_FIFO_DEPTH 4

// Data RAM word address width
`define DEX_RAM_AW 6

`endif

// File: sim.f
+incdir+include
hw/dex_pkg.sv
hw/pair_fifo.sv
hw/dex_regfile.sv
hw/issue_stage.sv
hw/ex_forward.sv
hw/load_unit.sv
hw/ex_stage.sv
hw/dex_top.sv
dv/tb_dex_top.sv
